//--- src.f
+incdir+verification
verilog/wb_intercon_pkg.sv
verilog/wb_req_if.sv
verilog/wbs_addr_decoder.sv
verilog/wbs_timeout.sv
verilog/wbs_resp_mux.sv
verilog/wbs_sub_arbiter.sv
verilog/wb_intercon_top.sv
verification/wb_intercon_tb.sv

//--- verification/wb_intercon_tasks.svh
`ifndef WB_INTERCON_TASKS_SVH
`define WB_INTERCON_TASKS_SVH

// One classic cycle from the master side, held until ack or err
task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                         input wb_sel_t sel, output wb_data_t rdat);
  @(posedge wb_clk_i);
  wbm_cyc_i <= 1'b1;
  wbm_stb_i <= 1'b1;
  wbm_we_i  <= we;
  wbm_adr_i <= adr;
  wbm_dat_i <= dat;
  wbm_sel_i <= sel;
  got_ack    = 1'b0;
  got_err    = 1'b0;
  got_cycles = 0;
  rdat       = '0;
  while (!got_ack && !got_err && got_cycles < MAX_WAIT) begin
    @(posedge wb_clk_i);
    got_cycles++;
    got_ack = wbm_ack_o;
    got_err = wbm_err_o;
    rdat    = wbm_dat_o;
  end
  wbm_cyc_i <= 1'b0;
  wbm_stb_i <= 1'b0;
  wbm_we_i  <= 1'b0;
  if (!got_ack && !got_err) begin
    $display("No ack or err from the interconnect for address %h at %0t", adr, $time);
    fail_cnt++;
  end
endtask

task automatic compare_data(input wb_data_t got, input wb_data_t exp, input string what);
  if (got !== exp) begin
    $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic compare_addr(input wb_addr_t got, input wb_addr_t exp, input string what);
  if (got !== exp) begin
    $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic compare_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    fail_cnt++;
  end else begin
    pass_cnt++;
  end
endtask

task automatic report_test(input string name, input int fails_before);
  if (fail_cnt == fails_before) begin
    $display("test %s: ok", name);
  end else begin
    $display("test %s: %0d errors", name, fail_cnt - fails_before);
  end
endtask

task automatic snap_cycles();
  for (int i = 0; i < N_SLAVES; i++) begin
    cyc_before[i] = cyc_cnt[i];
  end
endtask

// Slave s alone saw one new cycle, s < 0 means none did
task automatic check_route(input int s, input wb_addr_t off);
  for (int i = 0; i < N_SLAVES; i++) begin
    compare_data(wb_data_t'(cyc_cnt[i] - cyc_before[i]), (i == s) ? 32'd1 : 32'd0,
                 $sformatf("cycles seen by slave %0d", i));
  end
  if (s >= 0) begin
    compare_addr(last_adr[s], off, "rebased slave address");
  end
endtask

task automatic routed_access(input logic we, input int s, input wb_addr_t off,
                             input wb_data_t dat, input wb_sel_t sel, output wb_data_t rd);
  snap_cycles();
  wb_access(we, base_of(s) + off, dat, sel, rd);
  compare_flag(got_ack, 1'b1, "master ack");
  check_route(s, off);
endtask

task automatic check_idle(input string when);
  compare_flag(wbm_ack_o, 1'b0, {"wbm_ack_o ", when});
  compare_flag(wbm_err_o, 1'b0, {"wbm_err_o ", when});
  compare_flag((|wbs_cyc_o) || (|wbs_stb_o), 1'b0, {"slave cyc/stb ", when});
endtask

task automatic test_reset();
  int f0;
  f0 = fail_cnt;
  repeat (2) @(posedge wb_clk_i);
  check_idle("during reset");
  wb_rst_i <= 1'b0;
  // Outputs of the first edge out of reset
  repeat (2) @(posedge wb_clk_i);
  check_idle("after reset");
  report_test("reset", f0);
endtask

task automatic test_routing();
  int       f0;
  wb_addr_t off;
  wb_data_t dat;
  wb_data_t rd;
  f0 = fail_cnt;
  for (int s = 0; s < N_SLAVES; s++) begin
    off = wb_addr_t'(take_bits(6)) << 2;
    dat = take_bits(32);
    routed_access(1'b1, s, off, dat, 4'hf, rd);
    routed_access(1'b0, s, off, '0, 4'hf, rd);
    compare_data(rd, dat, "read-back");
  end
  report_test("routing", f0);
endtask

task automatic test_byte_sel();
  int       f0;
  wb_addr_t off;
  wb_data_t a;
  wb_data_t b;
  wb_data_t mask;
  wb_data_t rd;
  f0   = fail_cnt;
  off  = wb_addr_t'(take_bits(6)) << 2;
  a    = take_bits(32);
  b    = take_bits(32);
  // Bytes 1 and 2 come from the second write
  mask = 32'h00ff_ff00;
  routed_access(1'b1, 2, off, a, 4'hf, rd);
  routed_access(1'b1, 2, off, b, 4'b0110, rd);
  compare_data(wb_data_t'(last_sel[2]), 32'h6, "slave byte select");
  compare_data(mem[2][off[7:2]], (b & mask) | (a & ~mask), "slave memory word");
  routed_access(1'b0, 2, off, '0, 4'hf, rd);
  compare_data(rd, (b & mask) | (a & ~mask), "merged read-back");
  report_test("byte_sel", f0);
endtask

task automatic test_unmapped();
  int       f0;
  wb_data_t rd;
  f0 = fail_cnt;
  snap_cycles();
  wb_access(1'b1, 32'h0000_0ffc, take_bits(32), 4'hf, rd);
  compare_flag(got_err, 1'b1, "err below window 0");
  compare_flag(got_ack, 1'b0, "ack below window 0");
  wb_access(1'b0, 32'h0000_1100, '0, 4'hf, rd);
  compare_flag(got_err, 1'b1, "err above window 0");
  compare_flag(got_ack, 1'b0, "ack above window 0");
  check_route(-1, '0);
  report_test("unmapped", f0);
endtask

task automatic test_slave_err();
  int       f0;
  wb_data_t dat;
  wb_data_t rd;
  f0 = fail_cnt;
  slave_mode[1] = MODE_ERR;
  wb_access(1'b1, base_of(1) + 32'h10, take_bits(32), 4'hf, rd);
  compare_flag(got_err, 1'b1, "err from slave in error mode");
  compare_flag(got_ack, 1'b0, "ack from slave in error mode");
  slave_mode[1] = MODE_OK;
  dat = take_bits(32);
  routed_access(1'b1, 1, 32'h10, dat, 4'hf, rd);
  routed_access(1'b0, 1, 32'h10, '0, 4'hf, rd);
  compare_data(rd, dat, "read after slave err");
  slave_mode[3] = MODE_SILENT;
  wb_access(1'b0, base_of(3) + 32'h8, '0, 4'hf, rd);
  compare_flag(got_err, 1'b1, "err from silent slave");
  // The slave cycle opens two edges after the request and err is seen one edge late
  compare_flag(got_cycles - 3 >= TIMEOUT, 1'b1, "timeout not before its limit");
  compare_flag(|wbs_cyc_o, 1'b0, "slave cycle closed after timeout");
  slave_mode[3] = MODE_OK;
  dat = take_bits(32);
  routed_access(1'b1, 3, 32'h8, dat, 4'hf, rd);
  routed_access(1'b0, 3, 32'h8, '0, 4'hf, rd);
  compare_data(rd, dat, "read after timeout");
  report_test("slave_err", f0);
endtask

task automatic test_wait_states();
  int       f0;
  int       acks0;
  int       s;
  wb_addr_t off;
  wb_data_t dat;
  wb_data_t rd;
  f0 = fail_cnt;
  @(posedge wb_clk_i);
  acks0 = ack_total;
  for (int k = 0; k < 8; k++) begin
    s           = int'(take_bits(2));
    wait_cfg[s] = int'(take_bits(3));
    off         = wb_addr_t'(take_bits(6)) << 2;
    dat         = take_bits(32);
    routed_access(1'b1, s, off, dat, 4'hf, rd);
    routed_access(1'b0, s, off, '0, 4'hf, rd);
    compare_data(rd, dat, $sformatf("read-back with %0d wait states", wait_cfg[s]));
  end
  @(posedge wb_clk_i);
  compare_data(wb_data_t'(ack_total - acks0), 32'd16, "master acks for 16 transactions");
  for (int i = 0; i < N_SLAVES; i++) begin
    wait_cfg[i] = 0;
  end
  report_test("wait_states", f0);
endtask

`endif

//--- verification/wb_intercon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_intercon_tb
  import wb_intercon_pkg::*;
();

  localparam int N_SLAVES    = 4;
  localparam int TIMEOUT     = 10;
  localparam int CLK_HALF    = 2;
  localparam int MAX_WAIT    = TIMEOUT + 16;
  // Routing 8, byte select 3, unmapped 2, slave error 6, wait states 16
  localparam int N_TRANS     = 35;
  localparam int MODE_OK     = 0;
  localparam int MODE_ERR    = 1;
  localparam int MODE_SILENT = 2;

  logic                       wb_clk_i;
  logic                       wb_rst_i;
  logic                       wbm_cyc_i;
  logic                       wbm_stb_i;
  logic                       wbm_we_i;
  wb_sel_t                    wbm_sel_i;
  wb_addr_t                   wbm_adr_i;
  wb_data_t                   wbm_dat_i;
  wb_data_t                   wbm_dat_o;
  logic                       wbm_ack_o;
  logic                       wbm_err_o;
  logic [N_SLAVES-1:0]        wbs_cyc_o;
  logic [N_SLAVES-1:0]        wbs_stb_o;
  logic                       wbs_we_o;
  wb_sel_t                    wbs_sel_o;
  wb_addr_t                   wbs_adr_o;
  wb_data_t                   wbs_dat_o;
  logic [N_SLAVES*DATA_W-1:0] wbs_dat_i = '0;
  logic [N_SLAVES-1:0]        wbs_ack_i = '0;
  logic [N_SLAVES-1:0]        wbs_err_i = '0;

  // Slave model state
  wb_data_t mem [N_SLAVES][64];
  int       wait_cfg [N_SLAVES]   = '{default: 0};
  int       wait_ct [N_SLAVES]    = '{default: 0};
  int       slave_mode [N_SLAVES] = '{default: 0};
  int       cyc_cnt [N_SLAVES]    = '{default: 0};
  int       cyc_before [N_SLAVES];
  logic     served [N_SLAVES]     = '{default: 1'b0};
  logic     cyc_q [N_SLAVES]      = '{default: 1'b0};
  wb_addr_t last_adr [N_SLAVES];
  wb_sel_t  last_sel [N_SLAVES];

  // Results
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int          ack_total = 0;
  int          got_cycles;
  logic        got_ack;
  logic        got_err;
  logic [31:0] lfsr_q    = 32'hdefe_f80d;

  wb_intercon_top #(
    .N_SLAVES (N_SLAVES),
    .TIMEOUT  (TIMEOUT)
  ) wb_intercon_top_i (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever begin
      #CLK_HALF wb_clk_i = ~wb_clk_i;
    end
  end

  // Galois LFSR, one step per random bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hd000_0001) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic wb_addr_t base_of(input int s);
    case (s)
      0:       return 32'h0000_1000;
      1:       return 32'h0000_2000;
      2:       return 32'h0000_3000;
      default: return 32'h0000_8000;
    endcase
  endfunction

  // Slave memory models, one answer per opened cycle
  always @(posedge wb_clk_i) begin
    for (int s = 0; s < N_SLAVES; s++) begin
      wbs_ack_i[s] <= 1'b0;
      wbs_err_i[s] <= 1'b0;
      cyc_q[s]     <= wbs_cyc_o[s];
      if (wbs_cyc_o[s] && !cyc_q[s]) begin
        cyc_cnt[s]  <= cyc_cnt[s] + 1;
        last_adr[s] <= wbs_adr_o;
        last_sel[s] <= wbs_sel_o;
      end
      if (!wbs_cyc_o[s]) begin
        served[s]  <= 1'b0;
        wait_ct[s] <= 0;
      end else if (wbs_stb_o[s] && !served[s]) begin
        if (wait_ct[s] < wait_cfg[s]) begin
          wait_ct[s] <= wait_ct[s] + 1;
        end else if (slave_mode[s] == MODE_ERR) begin
          wbs_err_i[s] <= 1'b1;
          served[s]    <= 1'b1;
        end else if (slave_mode[s] == MODE_OK) begin
          wbs_ack_i[s] <= 1'b1;
          served[s]    <= 1'b1;
          if (wbs_we_o) begin
            for (int b = 0; b < SEL_W; b++) begin
              if (wbs_sel_o[b]) begin
                mem[s][wbs_adr_o[7:2]][b*8 +: 8] <= wbs_dat_o[b*8 +: 8];
              end
            end
          end else begin
            wbs_dat_i[s*DATA_W +: DATA_W] <= mem[s][wbs_adr_o[7:2]];
          end
        end
      end
    end
  end

  always @(posedge wb_clk_i) begin
    if (wbm_ack_o === 1'b1) begin
      ack_total <= ack_total + 1;
    end
  end

  // Watchdog
  initial begin
    #((N_TRANS * MAX_WAIT + 16) * 2 * CLK_HALF);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

  `include "wb_intercon_tasks.svh"

  initial begin
    wb_rst_i  = 1'b1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_we_i  = 1'b0;
    wbm_sel_i = '0;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    for (int s = 0; s < N_SLAVES; s++) begin
      for (int w = 0; w < 64; w++) begin
        mem[s][w] = (base_of(s) + 32'(w * 4)) ^ 32'h5a5a_0000;
      end
    end
    test_reset();
    test_routing();
    test_byte_sel();
    test_unmapped();
    test_slave_err();
    test_wait_states();
    $display("Summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/wb_intercon_pkg.sv
`default_nettype none

package wb_intercon_pkg;

  // Bus widths of the 32-bit classic-cycle Wishbone bus
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [DATA_W-1:0] wb_data_t;
  typedef logic [SEL_W-1:0]  wb_sel_t;

  // Width needed to hold values 0 .. n-1, never less than one bit
  function automatic int bits_for(input int n);
    int w;
    if (n > 1) begin
      w = $clog2(n);
    end else begin
      w = 1;
    end
    return w;
  endfunction

endpackage

`default_nettype wire

//--- verilog/wb_intercon_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_intercon_top
  import wb_intercon_pkg::*;
#(
  parameter int                          N_SLAVES   = 4,
  parameter logic [N_SLAVES*ADDR_W-1:0] SLAVE_ADDR = {32'h0000_8000, 32'h0000_3000,
                                                       32'h0000_2000, 32'h0000_1000},
  parameter logic [N_SLAVES*ADDR_W-1:0] SLAVE_HIGH = {32'h0000_80ff, 32'h0000_30ff,
                                                       32'h0000_20ff, 32'h0000_10ff},
  parameter int                          TIMEOUT    = 10
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  // Master side
  input  logic                       wbm_cyc_i,
  input  logic                       wbm_stb_i,
  input  logic                       wbm_we_i,
  input  wb_sel_t                    wbm_sel_i,
  input  wb_addr_t                   wbm_adr_i,
  input  wb_data_t                   wbm_dat_i,
  output wb_data_t                   wbm_dat_o,
  output logic                       wbm_ack_o,
  output logic                       wbm_err_o,
  // Slave side
  output logic [N_SLAVES-1:0]        wbs_cyc_o,
  output logic [N_SLAVES-1:0]        wbs_stb_o,
  output logic                       wbs_we_o,
  output wb_sel_t                    wbs_sel_o,
  output wb_addr_t                   wbs_adr_o,
  output wb_data_t                   wbs_dat_o,
  input  logic [N_SLAVES*DATA_W-1:0] wbs_dat_i,
  input  logic [N_SLAVES-1:0]        wbs_ack_i,
  input  logic [N_SLAVES-1:0]        wbs_err_i
);

  localparam int IDX_W = bits_for(N_SLAVES);

  logic [N_SLAVES-1:0] hit;
  logic [IDX_W-1:0]    hit_idx;
  wb_addr_t            offset_adr;
  logic [N_SLAVES-1:0] active;
  logic [IDX_W-1:0]    active_idx;
  logic                rsp_ack;
  logic                rsp_err;
  wb_data_t            rsp_dat;
  logic                run;
  logic                expired;

  wb_req_if req_if ();

  wbs_addr_decoder #(
    .N_SLAVES   (N_SLAVES),
    .SLAVE_ADDR (SLAVE_ADDR),
    .SLAVE_HIGH (SLAVE_HIGH)
  ) wbs_addr_decoder_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wbm_cyc_i    (wbm_cyc_i),
    .wbm_stb_i    (wbm_stb_i),
    .wbm_we_i     (wbm_we_i),
    .wbm_sel_i    (wbm_sel_i),
    .wbm_adr_i    (wbm_adr_i),
    .wbm_dat_i    (wbm_dat_i),
    .req          (req_if.src),
    .hit_o        (hit),
    .hit_idx_o    (hit_idx),
    .offset_adr_o (offset_adr)
  );

  wbs_timeout #(
    .TIMEOUT (TIMEOUT)
  ) wbs_timeout_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .run_i     (run),
    .expired_o (expired)
  );

  wbs_resp_mux #(
    .N_SLAVES (N_SLAVES)
  ) wbs_resp_mux_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .wbs_dat_i    (wbs_dat_i),
    .wbs_ack_i    (wbs_ack_i),
    .wbs_err_i    (wbs_err_i),
    .active_i     (active),
    .active_idx_i (active_idx),
    .rsp_ack_o    (rsp_ack),
    .rsp_err_o    (rsp_err),
    .rsp_dat_o    (rsp_dat)
  );

  wbs_sub_arbiter #(
    .N_SLAVES (N_SLAVES)
  ) wbs_sub_arbiter_i (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .req          (req_if.dst),
    .hit_i        (hit),
    .hit_idx_i    (hit_idx),
    .offset_adr_i (offset_adr),
    .rsp_ack_i    (rsp_ack),
    .rsp_err_i    (rsp_err),
    .rsp_dat_i    (rsp_dat),
    .expired_i    (expired),
    .run_o        (run),
    .active_o     (active),
    .active_idx_o (active_idx),
    .wbs_cyc_o    (wbs_cyc_o),
    .wbs_stb_o    (wbs_stb_o),
    .wbs_we_o     (wbs_we_o),
    .wbs_sel_o    (wbs_sel_o),
    .wbs_adr_o    (wbs_adr_o),
    .wbs_dat_o    (wbs_dat_o),
    .wbm_ack_o    (wbm_ack_o),
    .wbm_err_o    (wbm_err_o),
    .wbm_dat_o    (wbm_dat_o)
  );

endmodule

`default_nettype wire

//--- verilog/wb_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Registered master request, from the address decoder to the control FSM
interface wb_req_if
  import wb_intercon_pkg::*;
();

  logic     cyc;
  logic     stb;
  logic     we;
  wb_sel_t  sel;
  wb_addr_t adr;
  wb_data_t dat;

  // Decoder side
  modport src (
    output cyc, stb, we, sel, adr, dat
  );

  // FSM side
  modport dst (
    input cyc, stb, we, sel, adr, dat
  );

endinterface

`default_nettype wire

//--- verilog/wbs_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wbs_addr_decoder
  import wb_intercon_pkg::*;
#(
  parameter int                          N_SLAVES   = 4,
  parameter logic [N_SLAVES*ADDR_W-1:0] SLAVE_ADDR = '0,
  parameter logic [N_SLAVES*ADDR_W-1:0] SLAVE_HIGH = '0,
  localparam int                         IDX_W      = bits_for(N_SLAVES)
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                wbm_cyc_i,
  input  logic                wbm_stb_i,
  input  logic                wbm_we_i,
  input  wb_sel_t             wbm_sel_i,
  input  wb_addr_t            wbm_adr_i,
  input  wb_data_t            wbm_dat_i,
  wb_req_if.src               req,
  output logic [N_SLAVES-1:0] hit_o,
  output logic [IDX_W-1:0]    hit_idx_o,
  output wb_addr_t            offset_adr_o
);

  logic [N_SLAVES-1:0] hit_d;
  logic [N_SLAVES-1:0] hit_q;

  // Window compare on the raw master address, registered with the request
  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      hit_d[i] = (wbm_adr_i >= SLAVE_ADDR[i*ADDR_W +: ADDR_W]) &&
                 (wbm_adr_i <= SLAVE_HIGH[i*ADDR_W +: ADDR_W]);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      req.cyc <= 1'b0;
      req.stb <= 1'b0;
      hit_q   <= '0;
    end else begin
      req.cyc <= wbm_cyc_i;
      req.stb <= wbm_stb_i;
      hit_q   <= hit_d;
    end
  end

  // Payload of the request
  always_ff @(posedge wb_clk_i) begin
    req.we  <= wbm_we_i;
    req.sel <= wbm_sel_i;
    req.adr <= wbm_adr_i;
    req.dat <= wbm_dat_i;
  end

  // Lowest matching window wins when windows overlap
  always_comb begin
    hit_idx_o = '0;
    for (int i = N_SLAVES - 1; i >= 0; i--) begin
      if (hit_q[i]) begin
        hit_idx_o = IDX_W'(i);
      end
    end
  end

  assign hit_o = hit_q & (~hit_q + 1'b1);

  // Rebase to the start of the selected window
  assign offset_adr_o = req.adr - SLAVE_ADDR[hit_idx_o*ADDR_W +: ADDR_W];

endmodule

`default_nettype wire

//--- verilog/wbs_resp_mux.sv
`timescale 1ns/1ps
`default_nettype none

module wbs_resp_mux
  import wb_intercon_pkg::*;
#(
  parameter int  N_SLAVES = 4,
  localparam int IDX_W    = bits_for(N_SLAVES)
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic [N_SLAVES*DATA_W-1:0] wbs_dat_i,
  input  logic [N_SLAVES-1:0]        wbs_ack_i,
  input  logic [N_SLAVES-1:0]        wbs_err_i,
  input  logic [N_SLAVES-1:0]        active_i,
  input  logic [IDX_W-1:0]           active_idx_i,
  output logic                       rsp_ack_o,
  output logic                       rsp_err_o,
  output wb_data_t                   rsp_dat_o
);

  logic [N_SLAVES*DATA_W-1:0] dat_q;
  logic [N_SLAVES-1:0]        ack_q;
  logic [N_SLAVES-1:0]        err_q;

  // Response capture stage
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= '0;
      err_q <= '0;
    end else begin
      ack_q <= wbs_ack_i;
      err_q <= wbs_err_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    dat_q <= wbs_dat_i;
  end

  // Only the slave that owns the open cycle may answer
  assign rsp_ack_o = |(ack_q & active_i);
  assign rsp_err_o = |(err_q & active_i);

  // Read data of the active slave
  assign rsp_dat_o = dat_q[active_idx_i*DATA_W +: DATA_W];

endmodule

`default_nettype wire

//--- verilog/wbs_sub_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbs_sub_arbiter
  import wb_intercon_pkg::*;
#(
  parameter int  N_SLAVES = 4,
  localparam int IDX_W    = bits_for(N_SLAVES)
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  wb_req_if.dst               req,
  input  logic [N_SLAVES-1:0] hit_i,
  input  logic [IDX_W-1:0]    hit_idx_i,
  input  wb_addr_t            offset_adr_i,
  input  logic                rsp_ack_i,
  input  logic                rsp_err_i,
  input  wb_data_t            rsp_dat_i,
  input  logic                expired_i,
  output logic                run_o,
  output logic [N_SLAVES-1:0] active_o,
  output logic [IDX_W-1:0]    active_idx_o,
  output logic [N_SLAVES-1:0] wbs_cyc_o,
  output logic [N_SLAVES-1:0] wbs_stb_o,
  output logic                wbs_we_o,
  output wb_sel_t             wbs_sel_o,
  output wb_addr_t            wbs_adr_o,
  output wb_data_t            wbs_dat_o,
  output logic                wbm_ack_o,
  output logic                wbm_err_o,
  output wb_data_t            wbm_dat_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state_q;
  logic       req_valid;
  logic       open_slave;
  logic       take_data;

  assign req_valid  = req.cyc && req.stb;
  assign open_slave = (state_q == ST_IDLE) && req_valid && (|hit_i);
  assign take_data  = (state_q == ST_WAIT) && rsp_ack_i;

  // Timer runs only while a slave cycle is open
  assign run_o = (state_q == ST_WAIT);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= ST_IDLE;
      active_o  <= '0;
      wbs_cyc_o <= '0;
      wbs_stb_o <= '0;
      wbm_ack_o <= 1'b0;
      wbm_err_o <= 1'b0;
    end else begin
      // Master responses are single-cycle pulses
      wbm_ack_o <= 1'b0;
      wbm_err_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (req_valid) begin
            if (|hit_i) begin
              active_o  <= hit_i;
              wbs_cyc_o <= hit_i;
              wbs_stb_o <= hit_i;
              state_q   <= ST_WAIT;
            end else begin
              // Unmapped address
              wbm_err_o <= 1'b1;
              state_q   <= ST_DONE;
            end
          end
        end
        ST_WAIT: begin
          if (rsp_ack_i || rsp_err_i || expired_i) begin
            wbm_ack_o <= rsp_ack_i;
            wbm_err_o <= !rsp_ack_i;
            active_o  <= '0;
            wbs_cyc_o <= '0;
            wbs_stb_o <= '0;
            state_q   <= ST_DONE;
          end
        end
        ST_DONE: begin
          // Hold off until the master ends its strobe
          if (!req.stb) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Slave payload, stable for the whole slave cycle
  always_ff @(posedge wb_clk_i) begin
    if (open_slave) begin
      active_idx_o <= hit_idx_i;
      wbs_we_o     <= req.we;
      wbs_sel_o    <= req.sel;
      wbs_adr_o    <= offset_adr_i;
      wbs_dat_o    <= req.dat;
    end
  end

  // Read data returned with the master ack
  always_ff @(posedge wb_clk_i) begin
    if (take_data) begin
      wbm_dat_o <= rsp_dat_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/wbs_timeout.sv
`timescale 1ns/1ps
`default_nettype none

module wbs_timeout
  import wb_intercon_pkg::*;
#(
  parameter int TIMEOUT = 10
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic run_i,
  output logic expired_o
);

  localparam int CNT_W = bits_for(TIMEOUT + 1);

  logic [CNT_W-1:0] count_q;

  // Wait cycle counter, saturates at the limit
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !run_i) begin
      count_q <= '0;
    end else if (count_q != CNT_W'(TIMEOUT)) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired_o = run_i && (count_q == CNT_W'(TIMEOUT));

endmodule

`default_nettype wire
